// ==== include/vc_settings.svh ====
`ifndef VC_SETTINGS_SVH
`define VC_SETTINGS_SVH

// sources in priority order: west, east, south, north, extra.
`define VC_NUM_SRC          5
`define VC_NUM_CHANNEL      2
`define VC_NUM_BLOCK        4
`define VC_NUM_BANK         8
`define VC_PLD_WIDTH        16

// a bank stays blocked for this many cycles after its write is granted.
`define VC_WR_BUSY_CYCLES   4

`endif

// ==== verilog/vc_cache_pkg.sv ====
`include "vc_settings.svh"

package vc_cache_pkg;

    // numeric value equals the bank index, channel on top.
    typedef struct packed {
        logic [$clog2(`VC_NUM_CHANNEL)-1:0] channel_id;
        logic [$clog2(`VC_NUM_BLOCK)-1:0]   block_id;
    } vc_bank_id_t;

    typedef struct packed {
        logic                       vld;
        vc_bank_id_t                bank_id;
        logic [`VC_PLD_WIDTH-1:0]   pld;
    } vc_req_t;

    typedef vc_req_t [`VC_NUM_SRC-1:0] vc_req_vec_t;  // index 4 is west, 0 is extra.

    typedef enum logic [2:0] {
        SRC_EXTRA = 3'd0,
        SRC_NORTH = 3'd1,
        SRC_SOUTH = 3'd2,
        SRC_EAST  = 3'd3,
        SRC_WEST  = 3'd4
    } vc_src_e;

    typedef logic [`VC_NUM_BANK-1:0] vc_bank_mask_t;

endpackage

// ==== verilog/vc_arb_pkg.sv ====
`include "vc_settings.svh"

package vc_arb_pkg;

    typedef enum logic [1:0] {
        CMD_IDLE  = 2'd0,
        CMD_READ  = 2'd1,
        CMD_WRITE = 2'd2
    } vc_cmd_op_e;

    // one command toward the data RAM.
    typedef struct packed {
        vc_cmd_op_e                 op;
        vc_cache_pkg::vc_src_e      src;
        vc_cache_pkg::vc_bank_id_t  bank_id;
        logic [`VC_PLD_WIDTH-1:0]   pld;
    } vc_ram_cmd_t;

endpackage

// ==== verilog/vc_req_filter.sv ====
`timescale 1ns/1ps
`include "vc_settings.svh"

module vc_req_filter (
    input  vc_cache_pkg::vc_req_vec_t   rd_req,
    input  vc_cache_pkg::vc_req_vec_t   wr_req,
    input  vc_cache_pkg::vc_bank_mask_t busy,
    output logic [`VC_NUM_SRC-1:0]      rd_ok,
    output logic [`VC_NUM_SRC-1:0]      wr_ok
);
    import vc_cache_pkg::*;

    logic [`VC_NUM_SRC-1:0] rd_free;    // valid read whose bank is idle.
    vc_bank_mask_t          rd_claim;

    // every source sees the same bank view.
    always_comb begin
        for (int i = 0; i < `VC_NUM_SRC; i++) begin
            rd_free[i] = rd_req[i].vld && !busy[rd_req[i].bank_id];
            wr_ok[i]   = wr_req[i].vld && !busy[wr_req[i].bank_id];
        end
    end

    // walk from west down to extra.
    // the first read to reach a bank claims it and later ones are dropped,
    // so the reads that survive all target distinct banks.
    always_comb begin
        rd_claim = '0;
        rd_ok    = '0;
        for (int i = `VC_NUM_SRC - 1; i >= 0; i--) begin
            if (rd_free[i] && !rd_claim[rd_req[i].bank_id]) begin
                rd_ok[i]                    = 1'b1;
                rd_claim[rd_req[i].bank_id] = 1'b1;
            end
        end
    end

endmodule

// ==== verilog/vc_grant_arb.sv ====
`timescale 1ns/1ps
`include "vc_settings.svh"

module vc_grant_arb (
    input  logic                        clk,
    input  logic                        rst_n,
    input  vc_cache_pkg::vc_req_vec_t   rd_req,
    input  vc_cache_pkg::vc_req_vec_t   wr_req,
    input  logic [`VC_NUM_SRC-1:0]      rd_ok,
    input  logic [`VC_NUM_SRC-1:0]      wr_ok,
    output logic [`VC_NUM_SRC-1:0]      rd_rdy,
    output logic [`VC_NUM_SRC-1:0]      wr_rdy,
    output logic                        wr_grant_vld,
    output vc_cache_pkg::vc_bank_id_t   wr_grant_bank,
    output vc_arb_pkg::vc_ram_cmd_t     rd_cmd_0,
    output vc_arb_pkg::vc_ram_cmd_t     rd_cmd_1,
    output vc_arb_pkg::vc_ram_cmd_t     wr_cmd
);
    import vc_cache_pkg::*;
    import vc_arb_pkg::*;

    vc_src_e                wr_sel;
    vc_src_e                rd_sel_0;
    vc_src_e                rd_sel_1;
    logic                   rd_vld_0;
    logic                   rd_vld_1;
    logic [`VC_NUM_SRC-1:0] rd_cand;
    vc_ram_cmd_t            rd_cmd_0_d;
    vc_ram_cmd_t            rd_cmd_1_d;
    vc_ram_cmd_t            wr_cmd_d;

    function automatic vc_ram_cmd_t make_cmd(input logic       vld,
                                             input vc_cmd_op_e op,
                                             input vc_src_e    src,
                                             input vc_req_t    req);
        vc_ram_cmd_t cmd;
        if (vld)
            cmd.op = op;
        else
            cmd.op = CMD_IDLE;
        cmd.src     = src;
        cmd.bank_id = req.bank_id;
        cmd.pld     = req.pld;
        return cmd;
    endfunction

    always_comb begin
        wr_grant_vld = 1'b0;
        wr_sel       = SRC_EXTRA;
        wr_rdy       = '0;
        for (int i = `VC_NUM_SRC - 1; i >= 0; i--) begin
            if (wr_ok[i] && !wr_grant_vld) begin
                wr_grant_vld = 1'b1;
                wr_sel       = vc_src_e'(i);
                wr_rdy[i]    = 1'b1;
            end
        end
    end

    assign wr_grant_bank = wr_req[wr_sel].bank_id;  // only meaningful with wr_grant_vld.

    // a read to the bank being written this cycle has to wait.
    always_comb begin
        for (int i = 0; i < `VC_NUM_SRC; i++) begin
            rd_cand[i] = rd_ok[i] && !(wr_grant_vld && (rd_req[i].bank_id == wr_grant_bank));
        end
    end

    always_comb begin
        rd_vld_0 = 1'b0;
        rd_vld_1 = 1'b0;
        rd_sel_0 = SRC_EXTRA;
        rd_sel_1 = SRC_EXTRA;
        rd_rdy   = '0;
        for (int i = `VC_NUM_SRC - 1; i >= 0; i--) begin
            if (rd_cand[i] && !rd_vld_0) begin
                rd_vld_0  = 1'b1;
                rd_sel_0  = vc_src_e'(i);
                rd_rdy[i] = 1'b1;
            end else if (rd_cand[i] && !rd_vld_1) begin
                rd_vld_1  = 1'b1;
                rd_sel_1  = vc_src_e'(i);
                rd_rdy[i] = 1'b1;
            end
        end
    end

    assign rd_cmd_0_d = make_cmd(rd_vld_0, CMD_READ, rd_sel_0, rd_req[rd_sel_0]);
    assign rd_cmd_1_d = make_cmd(rd_vld_1, CMD_READ, rd_sel_1, rd_req[rd_sel_1]);
    assign wr_cmd_d   = make_cmd(wr_grant_vld, CMD_WRITE, wr_sel, wr_req[wr_sel]);

    // only the op fields are cleared by reset.
    always_ff @(posedge clk) begin
        rd_cmd_0 <= rd_cmd_0_d;
        rd_cmd_1 <= rd_cmd_1_d;
        wr_cmd   <= wr_cmd_d;
        if (!rst_n) begin
            rd_cmd_0.op <= CMD_IDLE;
            rd_cmd_1.op <= CMD_IDLE;
            wr_cmd.op   <= CMD_IDLE;
        end
    end

endmodule

// ==== verilog/vc_bank_busy_tracker.sv ====
`timescale 1ns/1ps
`include "vc_settings.svh"

module vc_bank_busy_tracker (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        wr_grant_vld,
    input  vc_cache_pkg::vc_bank_id_t   wr_grant_bank,
    output vc_cache_pkg::vc_bank_mask_t busy
);
    import vc_cache_pkg::*;

    vc_bank_mask_t                  bank_hit;   // one-hot decode of the granted bank.
    logic [`VC_WR_BUSY_CYCLES-1:0]  busy_sr [`VC_NUM_BANK];

    for (genvar b = 0; b < `VC_NUM_BANK; b++) begin : g_bank
        assign bank_hit[b] = wr_grant_vld && (wr_grant_bank == b);

        // a one enters at the bottom and drops off the top after the window.
        always_ff @(posedge clk) begin
            if (!rst_n) begin
                busy_sr[b] <= '0;
            end else begin
                busy_sr[b] <= {busy_sr[b][`VC_WR_BUSY_CYCLES-2:0], bank_hit[b]};
            end
        end

        assign busy[b] = |busy_sr[b];
    end

endmodule

// ==== verilog/vec_cache_stage2_arbiter.sv ====
`timescale 1ns/1ps
`include "vc_settings.svh"

module vec_cache_stage2_arbiter (
    input  logic                        clk,
    input  logic                        rst_n,
    input  vc_cache_pkg::vc_req_vec_t   rd_req,
    input  vc_cache_pkg::vc_req_vec_t   wr_req,
    output logic [`VC_NUM_SRC-1:0]      rd_rdy,
    output logic [`VC_NUM_SRC-1:0]      wr_rdy,
    output vc_arb_pkg::vc_ram_cmd_t     rd_cmd_0,
    output vc_arb_pkg::vc_ram_cmd_t     rd_cmd_1,
    output vc_arb_pkg::vc_ram_cmd_t     wr_cmd
);
    import vc_cache_pkg::*;

    logic [`VC_NUM_SRC-1:0] rd_ok;
    logic [`VC_NUM_SRC-1:0] wr_ok;
    logic                   wr_grant_vld;
    vc_bank_id_t            wr_grant_bank;
    vc_bank_mask_t          busy;           // fed back from the tracker into the filter.

    vc_req_filter u_req_filter (
        .rd_req         (rd_req         ),
        .wr_req         (wr_req         ),
        .busy           (busy           ),
        .rd_ok          (rd_ok          ),
        .wr_ok          (wr_ok          )
    );

    vc_grant_arb u_grant_arb (
        .clk            (clk            ),
        .rst_n          (rst_n          ),
        .rd_req         (rd_req         ),
        .wr_req         (wr_req         ),
        .rd_ok          (rd_ok          ),
        .wr_ok          (wr_ok          ),
        .rd_rdy         (rd_rdy         ),
        .wr_rdy         (wr_rdy         ),
        .wr_grant_vld   (wr_grant_vld   ),
        .wr_grant_bank  (wr_grant_bank  ),
        .rd_cmd_0       (rd_cmd_0       ),
        .rd_cmd_1       (rd_cmd_1       ),
        .wr_cmd         (wr_cmd         )
    );

    vc_bank_busy_tracker u_bank_busy_tracker (
        .clk            (clk            ),
        .rst_n          (rst_n          ),
        .wr_grant_vld   (wr_grant_vld   ),
        .wr_grant_bank  (wr_grant_bank  ),
        .busy           (busy           )
    );

endmodule

// ==== test/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int HALF_PERIOD  = 4,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;  // the flops still see reset at this edge.
    end

endmodule

// ==== test/vc_arbiter_properties.sv ====
`timescale 1ns/1ps

module vc_arbiter_properties (
    input logic                    clk,
    input logic                    rst_n,
    input vc_arb_pkg::vc_ram_cmd_t rd_cmd_0,
    input vc_arb_pkg::vc_ram_cmd_t rd_cmd_1,
    input vc_arb_pkg::vc_ram_cmd_t wr_cmd
);
    import vc_arb_pkg::*;

    int fail_count = 0;     // failed assertions so far, read by the testbench.

    // port 1 is only filled after port 0.
    a_rd1_needs_rd0: assert property (@(posedge clk) disable iff (!rst_n)
        rd_cmd_1.op == CMD_READ |-> rd_cmd_0.op == CMD_READ)
        else begin
            $error("rd_cmd_1 holds a read while rd_cmd_0 does not");
            fail_count++;
        end

    a_rd_banks_differ: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_cmd_0.op == CMD_READ && rd_cmd_1.op == CMD_READ) |->
        rd_cmd_0.bank_id != rd_cmd_1.bank_id)
        else begin
            $error("both read commands target bank %0d", rd_cmd_0.bank_id);
            fail_count++;
        end

    // the bank being written never serves a read in the same cycle.
    a_wr_rd_banks_differ: assert property (@(posedge clk) disable iff (!rst_n)
        wr_cmd.op == CMD_WRITE |->
        !(rd_cmd_0.op == CMD_READ && rd_cmd_0.bank_id == wr_cmd.bank_id) &&
        !(rd_cmd_1.op == CMD_READ && rd_cmd_1.bank_id == wr_cmd.bank_id))
        else begin
            $error("write command shares bank %0d with a read", wr_cmd.bank_id);
            fail_count++;
        end

endmodule

bind vec_cache_stage2_arbiter vc_arbiter_properties u_arbiter_properties (
    .clk        (clk        ),
    .rst_n      (rst_n      ),
    .rd_cmd_0   (rd_cmd_0   ),
    .rd_cmd_1   (rd_cmd_1   ),
    .wr_cmd     (wr_cmd     )
);

// ==== test/tb_vec_cache_stage2_arbiter.sv ====
`timescale 1ns/1ps
`include "vc_settings.svh"

module tb_vec_cache_stage2_arbiter;
    import vc_cache_pkg::*;
    import vc_arb_pkg::*;

    logic                   clk;
    logic                   rst_n;
    vc_req_vec_t            rd_req;
    vc_req_vec_t            wr_req;
    logic [`VC_NUM_SRC-1:0] rd_rdy;
    logic [`VC_NUM_SRC-1:0] wr_rdy;
    vc_ram_cmd_t            rd_cmd_0;
    vc_ram_cmd_t            rd_cmd_1;
    vc_ram_cmd_t            wr_cmd;

    int          busy_cnt [`VC_NUM_BANK];   // cycles left in each bank's busy window.
    logic [31:0] lfsr_state;
    int          errors;
    int          checks;
    int          tests;
    int          test_base;
    string       test_name;

    tb_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

    vec_cache_stage2_arbiter u_dut (
        .clk      (clk      ),
        .rst_n    (rst_n    ),
        .rd_req   (rd_req   ),
        .wr_req   (wr_req   ),
        .rd_rdy   (rd_rdy   ),
        .wr_rdy   (wr_rdy   ),
        .rd_cmd_0 (rd_cmd_0 ),
        .rd_cmd_1 (rd_cmd_1 ),
        .wr_cmd   (wr_cmd   )
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h80200003;   // taps 32, 22, 2 and 1.
        return s >> 1;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    // the request is valid only when all vld_bits random bits are ones.
    function automatic vc_req_t rand_req(input int vld_bits);
        vc_req_t     req;
        logic [31:0] bits;
        bits        = rand_bits(vld_bits);
        req.vld     = (bits == (32'd1 << vld_bits) - 32'd1);
        bits        = rand_bits(3);
        req.bank_id = bits[2:0];
        bits        = rand_bits(`VC_PLD_WIDTH);
        req.pld     = bits[`VC_PLD_WIDTH-1:0];
        return req;
    endfunction

    function automatic vc_req_t mk_req(input vc_bank_id_t bank, input logic [15:0] pld);
        vc_req_t req;
        req.vld     = 1'b1;
        req.bank_id = bank;
        req.pld     = pld;
        return req;
    endfunction

    function automatic vc_ram_cmd_t mk_cmd(input vc_cmd_op_e op, input vc_src_e src,
                                           input vc_bank_id_t bank, input logic [15:0] pld);
        vc_ram_cmd_t cmd;
        cmd.op      = op;
        cmd.src     = src;
        cmd.bank_id = bank;
        cmd.pld     = pld;
        return cmd;
    endfunction

    task automatic check_rdy(input string name, input logic [`VC_NUM_SRC-1:0] got,
                             input logic [`VC_NUM_SRC-1:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // an idle port only has a defined op field.
    task automatic check_cmd(input string name, input vc_ram_cmd_t got, input vc_ram_cmd_t exp);
        checks++;
        if (exp.op == CMD_IDLE && got.op !== CMD_IDLE) begin
            $display("Error: %s.op got %h expected %h", name, got.op, exp.op);
            errors++;
        end else if (exp.op != CMD_IDLE && got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_window(input string name, input int got);
        checks++;
        if (got != `VC_WR_BUSY_CYCLES) begin
            $display("Error: %s got %h expected %h", name, got, `VC_WR_BUSY_CYCLES);
            errors++;
        end
    endtask

    // one write first, then up to two reads in priority order.
    task automatic model_grant(input vc_req_vec_t rd, input vc_req_vec_t wr,
                               output logic [`VC_NUM_SRC-1:0] exp_rd,
                               output logic [`VC_NUM_SRC-1:0] exp_wr,
                               output vc_ram_cmd_t c0, output vc_ram_cmd_t c1,
                               output vc_ram_cmd_t cw, output int w_src);
        vc_bank_mask_t claimed;
        int            n_rd;
        exp_rd  = '0;
        exp_wr  = '0;
        claimed = '0;
        n_rd    = 0;
        w_src   = -1;
        c0      = mk_cmd(CMD_IDLE, SRC_EXTRA, 3'd0, 16'h0);
        c1      = c0;
        cw      = c0;
        for (int s = `VC_NUM_SRC - 1; s >= 0; s--) begin
            if (w_src < 0 && wr[s].vld && busy_cnt[wr[s].bank_id] == 0) begin
                w_src     = s;
                exp_wr[s] = 1'b1;
                cw        = mk_cmd(CMD_WRITE, vc_src_e'(s), wr[s].bank_id, wr[s].pld);
            end
        end
        for (int s = `VC_NUM_SRC - 1; s >= 0; s--) begin
            if (rd[s].vld && busy_cnt[rd[s].bank_id] == 0 && !claimed[rd[s].bank_id]) begin
                claimed[rd[s].bank_id] = 1'b1;
                if ((w_src < 0 || rd[s].bank_id != wr[w_src].bank_id) && n_rd < 2) begin
                    exp_rd[s] = 1'b1;
                    if (n_rd == 0)
                        c0 = mk_cmd(CMD_READ, vc_src_e'(s), rd[s].bank_id, rd[s].pld);
                    else
                        c1 = mk_cmd(CMD_READ, vc_src_e'(s), rd[s].bank_id, rd[s].pld);
                    n_rd++;
                end
            end
        end
    endtask

    // drives one request cycle from a falling edge and returns at the next one.
    task automatic run_cycle(input vc_req_vec_t rd, input vc_req_vec_t wr,
                             output logic [`VC_NUM_SRC-1:0] got_rd,
                             output logic [`VC_NUM_SRC-1:0] got_wr);
        logic [`VC_NUM_SRC-1:0] exp_rd;
        logic [`VC_NUM_SRC-1:0] exp_wr;
        vc_ram_cmd_t            exp_c0;
        vc_ram_cmd_t            exp_c1;
        vc_ram_cmd_t            exp_cw;
        int                     w_src;
        rd_req = rd;
        wr_req = wr;
        model_grant(rd, wr, exp_rd, exp_wr, exp_c0, exp_c1, exp_cw, w_src);
        #1;
        got_rd = rd_rdy;
        got_wr = wr_rdy;
        check_rdy("rd_rdy", got_rd, exp_rd);
        check_rdy("wr_rdy", got_wr, exp_wr);
        for (int b = 0; b < `VC_NUM_BANK; b++) begin
            if (busy_cnt[b] > 0)
                busy_cnt[b]--;
        end
        if (w_src >= 0)
            busy_cnt[wr[w_src].bank_id] = `VC_WR_BUSY_CYCLES;
        @(negedge clk);
        check_cmd("rd_cmd_0", rd_cmd_0, exp_c0);
        check_cmd("rd_cmd_1", rd_cmd_1, exp_c1);
        check_cmd("wr_cmd", wr_cmd, exp_cw);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_base = errors;
        tests++;
    endtask

    task automatic end_test();
        $display("test %0d %s finished with %0d errors", tests, test_name, errors - test_base);
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (rst_n !== 1'b1 && n < 40) begin
            @(negedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            $display("reset was not released within 40 cycles");
            errors++;
        end
    endtask

    // west keeps asking for the bank while south reads bank 1 alongside.
    task automatic count_busy_window(input logic use_write, input vc_bank_id_t bank,
                                     output int refused);
        vc_req_vec_t            rd;
        vc_req_vec_t            wr;
        logic [`VC_NUM_SRC-1:0] got_rd;
        logic [`VC_NUM_SRC-1:0] got_wr;
        logic                   granted;
        rd            = '0;
        wr            = '0;
        rd[SRC_SOUTH] = mk_req(3'd1, 16'h5a5a);
        if (use_write)
            wr[SRC_WEST] = mk_req(bank, 16'hbeef);
        else
            rd[SRC_WEST] = mk_req(bank, 16'hcafe);
        refused = 0;
        granted = 1'b0;
        while (!granted && refused < 20) begin
            run_cycle(rd, wr, got_rd, got_wr);
            granted = use_write ? got_wr[SRC_WEST] : got_rd[SRC_WEST];
            if (!got_rd[SRC_SOUTH]) begin
                $display("a read from south to an idle bank was refused");
                errors++;
            end
            if (!granted)
                refused++;
        end
        if (!granted) begin
            $display("the request to bank %0d was never granted", bank);
            errors++;
        end
    endtask

    task automatic test_reset_single_read();
        vc_req_vec_t            rd;
        vc_req_vec_t            wr;
        logic [`VC_NUM_SRC-1:0] got_rd;
        logic [`VC_NUM_SRC-1:0] got_wr;
        start_test("reset_and_single_read");
        check_cmd("rd_cmd_0", rd_cmd_0, mk_cmd(CMD_IDLE, SRC_EXTRA, 3'd0, 16'h0));
        check_cmd("rd_cmd_1", rd_cmd_1, mk_cmd(CMD_IDLE, SRC_EXTRA, 3'd0, 16'h0));
        check_cmd("wr_cmd", wr_cmd, mk_cmd(CMD_IDLE, SRC_EXTRA, 3'd0, 16'h0));
        rd            = '0;
        wr            = '0;
        rd[SRC_SOUTH] = mk_req(3'd3, 16'h1111);
        run_cycle(rd, wr, got_rd, got_wr);
        check_rdy("rd_rdy", got_rd, 5'b00100);
        check_cmd("rd_cmd_0", rd_cmd_0, mk_cmd(CMD_READ, SRC_SOUTH, 3'd3, 16'h1111));
        end_test();
    endtask

    task automatic test_two_read_ports();
        vc_req_vec_t            rd;
        vc_req_vec_t            wr;
        logic [`VC_NUM_SRC-1:0] got_rd;
        logic [`VC_NUM_SRC-1:0] got_wr;
        start_test("two_read_ports");
        rd            = '0;
        wr            = '0;
        rd[SRC_WEST]  = mk_req(3'd0, 16'h0a0a);
        rd[SRC_SOUTH] = mk_req(3'd1, 16'h0b0b);
        rd[SRC_EXTRA] = mk_req(3'd2, 16'h0c0c);
        run_cycle(rd, wr, got_rd, got_wr);
        check_rdy("rd_rdy", got_rd, 5'b10100);
        check_cmd("rd_cmd_0", rd_cmd_0, mk_cmd(CMD_READ, SRC_WEST, 3'd0, 16'h0a0a));
        check_cmd("rd_cmd_1", rd_cmd_1, mk_cmd(CMD_READ, SRC_SOUTH, 3'd1, 16'h0b0b));
        end_test();
    endtask

    task automatic test_same_bank_reads();
        vc_req_vec_t            rd;
        vc_req_vec_t            wr;
        logic [`VC_NUM_SRC-1:0] got_rd;
        logic [`VC_NUM_SRC-1:0] got_wr;
        start_test("same_bank_reads");
        rd            = '0;
        wr            = '0;
        rd[SRC_WEST]  = mk_req(3'd5, 16'h5555);
        rd[SRC_EAST]  = mk_req(3'd5, 16'h3333);
        rd[SRC_NORTH] = mk_req(3'd6, 16'h6666);
        run_cycle(rd, wr, got_rd, got_wr);
        check_rdy("rd_rdy", got_rd, 5'b10010);
        check_cmd("rd_cmd_1", rd_cmd_1, mk_cmd(CMD_READ, SRC_NORTH, 3'd6, 16'h6666));
        end_test();
    endtask

    task automatic test_write_blocks_read();
        vc_req_vec_t            rd;
        vc_req_vec_t            wr;
        logic [`VC_NUM_SRC-1:0] got_rd;
        logic [`VC_NUM_SRC-1:0] got_wr;
        start_test("write_blocks_read");
        rd            = '0;
        wr            = '0;
        rd[SRC_WEST]  = mk_req(3'd2, 16'h2020);
        wr[SRC_EAST]  = mk_req(3'd2, 16'h2222);
        wr[SRC_NORTH] = mk_req(3'd4, 16'h4444);
        run_cycle(rd, wr, got_rd, got_wr);
        check_rdy("wr_rdy", got_wr, 5'b01000);
        check_rdy("rd_rdy", got_rd, 5'b00000);
        check_cmd("wr_cmd", wr_cmd, mk_cmd(CMD_WRITE, SRC_EAST, 3'd2, 16'h2222));
        end_test();
    endtask

    task automatic test_bank_busy_window();
        vc_req_vec_t            rd;
        vc_req_vec_t            wr;
        logic [`VC_NUM_SRC-1:0] got_rd;
        logic [`VC_NUM_SRC-1:0] got_wr;
        int                     refused;
        start_test("bank_busy_window");
        rd           = '0;
        wr           = '0;
        wr[SRC_WEST] = mk_req(3'd6, 16'h0606);
        run_cycle(rd, wr, got_rd, got_wr);
        check_rdy("wr_rdy", got_wr, 5'b10000);
        count_busy_window(1'b1, 3'd6, refused);   // ends with a new write to bank 6.
        check_window("write_refused_cycles", refused);
        count_busy_window(1'b0, 3'd6, refused);
        check_window("read_refused_cycles", refused);
        end_test();
    endtask

    task automatic test_random_traffic();
        vc_req_vec_t            rd;
        vc_req_vec_t            wr;
        logic [`VC_NUM_SRC-1:0] got_rd;
        logic [`VC_NUM_SRC-1:0] got_wr;
        start_test("random_traffic");
        rd = '0;
        wr = '0;
        for (int c = 0; c < 50; c++) begin
            for (int s = 0; s < `VC_NUM_SRC; s++) begin
                if (!rd[s].vld)
                    rd[s] = rand_req(1);
                if (!wr[s].vld)
                    wr[s] = rand_req(2);   // writes are rarer so that banks free up.
            end
            run_cycle(rd, wr, got_rd, got_wr);
            for (int s = 0; s < `VC_NUM_SRC; s++) begin
                rd[s].vld = rd[s].vld && !got_rd[s];
                wr[s].vld = wr[s].vld && !got_wr[s];
            end
        end
        end_test();
    endtask

    initial begin
        rd_req     = '0;
        wr_req     = '0;
        lfsr_state = 32'h987b9020;
        errors     = 0;
        checks     = 0;
        tests      = 0;
        for (int b = 0; b < `VC_NUM_BANK; b++)
            busy_cnt[b] = 0;
        wait_reset_release();
        test_reset_single_read();
        test_two_read_ports();
        test_same_bank_reads();
        test_write_blocks_read();
        test_bank_busy_window();
        test_random_traffic();
        errors += u_dut.u_arbiter_properties.fail_count;
        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// ==== vec_cache_stage2_arbiter.f ====
+incdir+include
verilog/vc_cache_pkg.sv
verilog/vc_arb_pkg.sv
verilog/vc_req_filter.sv
verilog/vc_grant_arb.sv
verilog/vc_bank_busy_tracker.sv
verilog/vec_cache_stage2_arbiter.sv
test/tb_clk_gen.sv
test/vc_arbiter_properties.sv
test/tb_vec_cache_stage2_arbiter.sv
